//--- filelist.f
+incdir+include
hdl/cb_pkg.sv
hdl/lsu_pkg.sv
hdl/lsu_issue.sv
hdl/lsu.sv
hdl/lsu_wb_align.sv
hdl/data_ram.sv
hdl/lsu_top.sv
tests/tb_clkgen.sv
tests/lsu_assertions.sv
tests/lsu_tb.sv

//--- Bender.yml
package:
  name: lsu_subsystem

sources:
  - include_dirs:
      - include
    files:
      - hdl/cb_pkg.sv
      - hdl/lsu_pkg.sv
      - hdl/lsu_issue.sv
      - hdl/lsu.sv
      - hdl/lsu_wb_align.sv
      - hdl/data_ram.sv
      - hdl/lsu_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_clkgen.sv
      - tests/lsu_assertions.sv
      - tests/lsu_tb.sv

//--- tests/lsu_tb.sv
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_tb
  import lsu_pkg::*;
();
  localparam int N_RAND_OPS  = 200;
  localparam int N_DIR_OPS   = 50;
  // Issue handshake, bus phases, ack delay and response handshake
  localparam int WORST_LAT   = 24;
  localparam int CYCLE_LIMIT = (N_RAND_OPS + N_DIR_OPS) * WORST_LAT + 200;
  localparam int MAX_ACK_DLY = 7;

  logic       clk;
  logic       rst_n;
  s_lsu_op_t  op_in   = '0;
  logic       op_req  = 1'b0;
  logic       op_ack;
  s_lsu_rsp_t rsp;
  logic       rsp_req;
  logic       rsp_ack = 1'b0;

  integer     seed = 8;
  logic [7:0] ref_mem [`RAM_DEPTH*4];
  s_lsu_rsp_t exp_q [$];
  int         dly_q [$];
  int         err_cnt = 0;
  int         issued = 0;
  int         rsp_cnt = 0;
  int         tests_ok = 0;
  int         tests_bad = 0;
  int         test_idx = 0;
  int         test_err_mark = 0;
  int         cycles = 0;

  tb_clkgen clkgen_inst (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  lsu_top lsu_top_inst (
    .clk       (clk),
    .rst_n_i   (rst_n),
    .op_i      (op_in),
    .op_req_i  (op_req),
    .op_ack_o  (op_ack),
    .rsp_o     (rsp),
    .rsp_req_o (rsp_req),
    .rsp_ack_i (rsp_ack)
  );

  // Expected response of one op, applied to the byte model in issue order
  function automatic s_lsu_rsp_t model_op(s_lsu_op_t op);
    s_lsu_rsp_t       r;
    int               base;
    int               nbytes;
    logic [`XLEN-1:0] val;
    r.op_typ = op.op_typ;
    r.rdata  = '0;
    r.error  = (op.addr[`XLEN-1:2] >= `RAM_DEPTH);
    if (op.width inside {RV_LSU_B, RV_LSU_BU}) begin
      nbytes = 1;
    end else if (op.width inside {RV_LSU_H, RV_LSU_HU}) begin
      nbytes = 2;
    end else begin
      nbytes = 4;
    end
    base = int'(op.addr[`RAM_AW+1:0]);
    if (r.error) begin
      return r;
    end
    if (op.op_typ == LSU_STORE) begin
      for (int i = 0; i < nbytes; i++) begin
        ref_mem[base + i] = op.wdata[i*8 +: 8];
      end
    end else begin
      val = '0;
      for (int i = 0; i < nbytes; i++) begin
        val[i*8 +: 8] = ref_mem[base + i];
      end
      if (op.width == RV_LSU_B && val[7]) begin
        val[`XLEN-1:8] = '1;
      end
      if (op.width == RV_LSU_H && val[15]) begin
        val[`XLEN-1:16] = '1;
      end
      r.rdata = val;
    end
    return r;
  endfunction

  task automatic check_load(input s_lsu_rsp_t got, input s_lsu_rsp_t exp);
    if (got !== exp) begin
      err_cnt++;
      $display("[FAIL] %0t: load got typ %0d rdata %h error %b, expected rdata %h error %b",
               $time, got.op_typ, got.rdata, got.error, exp.rdata, exp.error);
    end
  endtask

  task automatic check_store(input s_lsu_rsp_t got, input s_lsu_rsp_t exp);
    if (got !== exp) begin
      err_cnt++;
      $display("[FAIL] %0t: store got typ %0d rdata %h error %b, expected error %b",
               $time, got.op_typ, got.rdata, got.error, exp.error);
    end
  endtask

  // Four-phase master on the issue port
  task automatic issue_op(input s_lsu_op_t op);
    exp_q.push_back(model_op(op));
    dly_q.push_back($unsigned($random(seed)) % MAX_ACK_DLY);
    issued++;
    @(negedge clk);
    op_in  = op;
    op_req = 1'b1;
    while (!op_ack) @(negedge clk);
    op_req = 1'b0;
    while (op_ack) @(negedge clk);
  endtask

  task automatic do_op(input lsu_op_typ_t typ, input lsu_w_t w,
                       input logic [`XLEN-1:0] addr, input logic [`XLEN-1:0] data);
    s_lsu_op_t op;
    op.op_typ = typ;
    op.width  = w;
    op.addr   = addr;
    op.wdata  = data;
    issue_op(op);
  endtask

  task automatic gen_random_op(output s_lsu_op_t op);
    int sel;
    sel = $unsigned($random(seed)) % 5;
    case (sel)
      0:       op.width = RV_LSU_B;
      1:       op.width = RV_LSU_H;
      2:       op.width = RV_LSU_W;
      3:       op.width = RV_LSU_BU;
      default: op.width = RV_LSU_HU;
    endcase
    op.op_typ = ($unsigned($random(seed)) % 2 == 0) ? LSU_LOAD : LSU_STORE;
    // Stores have no unsigned forms
    if (op.op_typ == LSU_STORE && op.width == RV_LSU_BU) begin
      op.width = RV_LSU_B;
    end
    if (op.op_typ == LSU_STORE && op.width == RV_LSU_HU) begin
      op.width = RV_LSU_H;
    end
    op.addr = $random(seed);
    if ($unsigned($random(seed)) % 8 == 0) begin
      op.addr[`RAM_AW+2] = 1'b1;
    end else begin
      // 16-word window so loads often hit earlier stores
      op.addr[`XLEN-1:6] = '0;
    end
    if (op.width inside {RV_LSU_H, RV_LSU_HU}) begin
      op.addr[0] = 1'b0;
    end
    if (op.width == RV_LSU_W) begin
      op.addr[1:0] = 2'b00;
    end
    op.wdata = $random(seed);
  endtask

  // Slave on the response port, checks each response against the queue head
  task automatic respond_loop();
    s_lsu_rsp_t exp;
    int         dly;
    forever begin
      @(negedge clk);
      if (rsp_req) begin
        rsp_cnt++;
        if (exp_q.size() == 0) begin
          err_cnt++;
          $display("Response arrived at %0t with no op outstanding", $time);
          dly = 0;
        end else begin
          exp = exp_q.pop_front();
          dly = dly_q.pop_front();
          if (exp.op_typ == LSU_LOAD) begin
            check_load(rsp, exp);
          end else begin
            check_store(rsp, exp);
          end
        end
        repeat (dly) @(negedge clk);
        rsp_ack = 1'b1;
        while (rsp_req) @(negedge clk);
        rsp_ack = 1'b0;
      end
    end
  endtask

  task automatic wait_drain();
    @(negedge clk);
    while (exp_q.size() != 0 || rsp_req || rsp_ack) begin
      @(negedge clk);
    end
  endtask

  task automatic end_test(input string name);
    int errs;
    wait_drain();
    errs = err_cnt - test_err_mark;
    test_idx++;
    if (errs == 0) begin
      tests_ok++;
      $display("Test %0d %s: ok", test_idx, name);
    end else begin
      tests_bad++;
      $display("Test %0d %s: %0d mismatches", test_idx, name, errs);
    end
    test_err_mark = err_cnt;
  endtask

  initial begin : watchdog
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, %0d responses still missing", cycles, exp_q.size());
    $display("Regression failed");
    $finish;
  end

  initial begin : main
    logic [`XLEN-1:0] base;
    logic [`XLEN-1:0] oor;
    s_lsu_op_t        rop;
    int               sva_fails;
    for (int i = 0; i < `RAM_DEPTH * 4; i++) begin
      ref_mem[i] = 8'h00;
    end
    wait (rst_n === 1'b1);
    fork
      respond_loop();
    join_none

    for (int i = 0; i < 4; i++) begin
      base = ($unsigned($random(seed)) % `RAM_DEPTH) << 2;
      do_op(LSU_STORE, RV_LSU_W, base, $random(seed));
      do_op(LSU_LOAD, RV_LSU_W, base, '0);
    end
    end_test("word store then load");

    // Upper bytes of wdata are junk and must be masked off
    base = 32'h80;
    do_op(LSU_STORE, RV_LSU_W, base, 32'h1122_3344);
    for (int i = 0; i < 4; i++) begin
      do_op(LSU_STORE, RV_LSU_B, base + i, $random(seed));
      do_op(LSU_LOAD, RV_LSU_W, base, '0);
    end
    for (int i = 0; i < 4; i += 2) begin
      do_op(LSU_STORE, RV_LSU_H, base + i, $random(seed));
      do_op(LSU_LOAD, RV_LSU_W, base, '0);
    end
    end_test("sub-word store lanes");

    base = 32'h40;
    do_op(LSU_STORE, RV_LSU_W, base, 32'h8F7E_C0A5);
    for (int i = 0; i < 4; i++) begin
      do_op(LSU_LOAD, RV_LSU_B, base + i, '0);
      do_op(LSU_LOAD, RV_LSU_BU, base + i, '0);
    end
    for (int i = 0; i < 4; i += 2) begin
      do_op(LSU_LOAD, RV_LSU_H, base + i, '0);
      do_op(LSU_LOAD, RV_LSU_HU, base + i, '0);
    end
    end_test("load sign and zero extension");

    // Out-of-range address aliases onto an in-range word of the RAM
    for (int i = 0; i < 4; i++) begin
      base = 32'h100 + i * 4;
      oor  = base | (1 << (`RAM_AW + 2));
      do_op(LSU_STORE, RV_LSU_W, base, $random(seed));
      do_op(LSU_STORE, (i % 2 == 0) ? RV_LSU_W : RV_LSU_B, oor + i % 2, $random(seed));
      do_op(LSU_LOAD, (i % 2 == 0) ? RV_LSU_W : RV_LSU_H, oor, '0);
      do_op(LSU_LOAD, RV_LSU_W, base, '0);
    end
    end_test("out-of-range access");

    for (int i = 0; i < N_RAND_OPS; i++) begin
      gen_random_op(rop);
      issue_op(rop);
    end
    end_test("random mix");

    if (issued != rsp_cnt) begin
      err_cnt++;
      $display("Response count wrong: %0d ops issued, %0d responses seen", issued, rsp_cnt);
    end
    sva_fails = lsu_top_inst.lsu_assertions_inst.fail_cnt;
    if (sva_fails != 0) begin
      err_cnt += sva_fails;
      $display("Bound checker saw %0d assertion failures", sva_fails);
    end
    $display("Summary: %0d tests ok, %0d tests bad, %0d ops, %0d errors",
             tests_ok, tests_bad, issued, err_cnt);
    if (err_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- tests/lsu_assertions.sv
`timescale 1ns/1ps

module lsu_assertions
  import cb_pkg::*;
  import lsu_pkg::*;
(
  input logic       clk,
  input logic       rst_n_i,
  input logic       op_req_i,
  input logic       op_ack_i,
  input s_lsu_rsp_t rsp_i,
  input logic       rsp_req_i,
  input logic       rsp_ack_i,
  input s_cb_mosi_t cb_mosi_i
);
  int unsigned cyc = 0;
  int          fail_cnt = 0;
  logic        any_valid;

  assign any_valid = cb_mosi_i.rd_addr_valid || cb_mosi_i.wr_addr_valid ||
                     cb_mosi_i.wr_data_valid;

  // Bus outputs are unknown until the first reset edge
  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  op_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n_i)
    $rose(op_ack_i) |-> $past(op_req_i))
    else begin
      $error("op_ack_o rose while op_req_i was low");
      fail_cnt++;
    end

  // Response master keeps its request up until the ack arrives
  rsp_req_held_for_ack: assert property (@(posedge clk) disable iff (!rst_n_i)
    $fell(rsp_req_i) |-> $past(rsp_ack_i))
    else begin
      $error("rsp_req_o dropped before rsp_ack_i rose");
      fail_cnt++;
    end

  rsp_held: assert property (@(posedge clk) disable iff (!rst_n_i)
    (rsp_req_i && $past(rsp_req_i)) |-> $stable(rsp_i))
    else begin
      $error("rsp_o changed while rsp_req_o was high");
      fail_cnt++;
    end

  no_valid_in_reset: assert property (@(posedge clk)
    (!rst_n_i && cyc != 0) |-> !any_valid)
    else begin
      $error("Core bus valid high during reset");
      fail_cnt++;
    end

endmodule

bind lsu_top lsu_assertions lsu_assertions_inst (
  .clk       (clk),
  .rst_n_i   (rst_n_i),
  .op_req_i  (op_req_i),
  .op_ack_i  (op_ack_o),
  .rsp_i     (rsp_o),
  .rsp_req_i (rsp_req_o),
  .rsp_ack_i (rsp_ack_i),
  .cb_mosi_i (data_cb_mosi)
);

//--- tests/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
  parameter int PERIOD     = 10,
  parameter int RST_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_n_o
);
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // Release on a falling edge, away from the sampling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

//--- hdl/lsu_top.sv
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_top
  import cb_pkg::*;
  import lsu_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n_i,
  input  s_lsu_op_t  op_i,
  input  logic       op_req_i,
  output logic       op_ack_o,
  output s_lsu_rsp_t rsp_o,
  output logic       rsp_req_o,
  input  logic       rsp_ack_i
);
  s_lsu_op_t        lsu_op;
  logic             lsu_bp;
  s_lsu_op_t        wb_lsu;
  logic [`XLEN-1:0] lsu_data;
  logic             lsu_done;
  logic             txn_error;
  logic             wb_busy;
  s_cb_mosi_t       data_cb_mosi;
  s_cb_miso_t       data_cb_miso;

  lsu_issue lsu_issue_inst (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .op_i     (op_i),
    .op_req_i (op_req_i),
    .op_ack_o (op_ack_o),
    .lsu_op_o (lsu_op),
    .lsu_bp_i (lsu_bp)
  );

  lsu lsu_inst (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .lsu_i          (lsu_op),
    .lsu_bp_o       (lsu_bp),
    .wb_lsu_o       (wb_lsu),
    .lsu_data_o     (lsu_data),
    .done_o         (lsu_done),
    .txn_error_o    (txn_error),
    .wb_busy_i      (wb_busy),
    .data_cb_mosi_o (data_cb_mosi),
    .data_cb_miso_i (data_cb_miso)
  );

  lsu_wb_align lsu_wb_align_inst (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .wb_lsu_i    (wb_lsu),
    .lsu_data_i  (lsu_data),
    .done_i      (lsu_done),
    .txn_error_i (txn_error),
    .wb_busy_o   (wb_busy),
    .rsp_o       (rsp_o),
    .rsp_req_o   (rsp_req_o),
    .rsp_ack_i   (rsp_ack_i)
  );

  data_ram data_ram_inst (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .cb_mosi_i (data_cb_mosi),
    .cb_miso_o (data_cb_miso)
  );

endmodule

//--- hdl/data_ram.sv
`timescale 1ns/1ps
`include "lsu_params.svh"

module data_ram
  import cb_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n_i,
  input  s_cb_mosi_t cb_mosi_i,
  output s_cb_miso_t cb_miso_o
);
  localparam int RD_LAT = `RAM_RD_LAT;

  logic [`XLEN-1:0]   mem [`RAM_DEPTH];
  logic [RD_LAT-1:0]  rd_vld_q;
  logic [RD_LAT-1:0]  rd_err_q;
  logic [`XLEN-1:0]   rd_data_q [RD_LAT];
  logic               rd_err;
  logic [`RAM_AW-1:0] wr_idx_ff;
  logic               wr_err_ff;
  logic               wr_dph_ff;
  logic               bresp_ff;
  logic               bresp_err_ff;
  logic               wr_hs;

  function automatic logic out_of_range(cb_addr_t addr);
    return addr[`XLEN-1:2] >= `RAM_DEPTH;
  endfunction

  function automatic logic [`RAM_AW-1:0] word_idx(cb_addr_t addr);
    return addr[`RAM_AW+1:2];
  endfunction

  always_comb begin
    rd_err = out_of_range(cb_mosi_i.rd_addr);
    wr_hs  = wr_dph_ff && cb_mosi_i.wr_data_valid;

    cb_miso_o.rd_addr_ready = 1'b1;
    cb_miso_o.rd_valid      = rd_vld_q[RD_LAT-1];
    cb_miso_o.rd_data       = rd_data_q[RD_LAT-1];
    cb_miso_o.rd_resp       = rd_err_q[RD_LAT-1] ? CB_SLVERR : CB_OKAY;
    cb_miso_o.wr_addr_ready = 1'b1;
    cb_miso_o.wr_data_ready = wr_dph_ff;
    cb_miso_o.wr_resp_valid = bresp_ff;
    cb_miso_o.wr_resp_error = bresp_err_ff ? CB_SLVERR : CB_OKAY;
  end

  // Read pipeline, one stage per cycle of latency
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      rd_vld_q <= '0;
      rd_err_q <= '0;
    end else begin
      for (int i = RD_LAT-1; i > 0; i--) begin
        rd_vld_q[i] <= rd_vld_q[i-1];
        rd_err_q[i] <= rd_err_q[i-1];
      end
      rd_vld_q[0] <= cb_mosi_i.rd_addr_valid;
      rd_err_q[0] <= cb_mosi_i.rd_addr_valid && rd_err;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = RD_LAT-1; i > 0; i--) begin
      rd_data_q[i] <= rd_data_q[i-1];
    end
    if (cb_mosi_i.rd_addr_valid) begin
      rd_data_q[0] <= rd_err ? '0 : mem[word_idx(cb_mosi_i.rd_addr)];
    end
  end

  // Write address, then data one cycle later, then the response
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      wr_dph_ff    <= 1'b0;
      wr_err_ff    <= 1'b0;
      bresp_ff     <= 1'b0;
      bresp_err_ff <= 1'b0;
      for (int i = 0; i < `RAM_DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else begin
      if (cb_mosi_i.wr_addr_valid) begin
        wr_dph_ff <= 1'b1;
        wr_idx_ff <= word_idx(cb_mosi_i.wr_addr);
        wr_err_ff <= out_of_range(cb_mosi_i.wr_addr);
      end else if (wr_hs) begin
        wr_dph_ff <= 1'b0;
      end

      if (wr_hs) begin
        bresp_ff     <= 1'b1;
        bresp_err_ff <= wr_err_ff;
        if (!wr_err_ff) begin
          for (int i = 0; i < `XLEN/8; i++) begin
            if (cb_mosi_i.wr_strobe[i]) begin
              mem[wr_idx_ff][i*8 +: 8] <= cb_mosi_i.wr_data[i*8 +: 8];
            end
          end
        end
      end else if (cb_mosi_i.wr_resp_ready) begin
        bresp_ff <= 1'b0;
      end
    end
  end

endmodule

//--- hdl/lsu_wb_align.sv
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_wb_align
  import lsu_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n_i,
  input  s_lsu_op_t        wb_lsu_i,
  input  logic [`XLEN-1:0] lsu_data_i,
  input  logic             done_i,
  input  logic             txn_error_i,
  output logic             wb_busy_o,
  output s_lsu_rsp_t       rsp_o,
  output logic             rsp_req_o,
  input  logic             rsp_ack_i
);
  issue_st_t        st_ff;
  issue_st_t        next_st;
  s_lsu_rsp_t       rsp_ff;
  s_lsu_rsp_t       next_rsp;
  logic [`XLEN-1:0] lane;
  logic             capture;

  always_comb begin
    // Addressed byte or half word lands in the low lanes
    lane = lsu_data_i >> {wb_lsu_i.addr[1:0], 3'b000};

    next_rsp.op_typ = wb_lsu_i.op_typ;
    next_rsp.error  = txn_error_i;
    case (wb_lsu_i.width)
      RV_LSU_B:  next_rsp.rdata = {{(`XLEN-8){lane[7]}}, lane[7:0]};
      RV_LSU_H:  next_rsp.rdata = {{(`XLEN-16){lane[15]}}, lane[15:0]};
      RV_LSU_BU: next_rsp.rdata = {{(`XLEN-8){1'b0}}, lane[7:0]};
      RV_LSU_HU: next_rsp.rdata = {{(`XLEN-16){1'b0}}, lane[15:0]};
      default:   next_rsp.rdata = lsu_data_i;
    endcase
    if (wb_lsu_i.op_typ != LSU_LOAD || txn_error_i) begin
      next_rsp.rdata = '0;
    end

    next_st = st_ff;
    capture = 1'b0;
    case (st_ff)
      IDLE: begin
        if (done_i) begin
          capture = 1'b1;
          next_st = HOLD;
        end
      end
      HOLD: begin
        if (rsp_ack_i) begin
          next_st = WAIT_REQ_LOW;
        end
      end
      WAIT_REQ_LOW: begin
        if (!rsp_ack_i) begin
          next_st = IDLE;
        end
      end
      default: next_st = IDLE;
    endcase

    rsp_req_o = (st_ff == HOLD);
    wb_busy_o = (st_ff != IDLE);
    rsp_o     = rsp_ff;
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      st_ff <= IDLE;
    end else begin
      st_ff <= next_st;
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      rsp_ff <= next_rsp;
    end
  end

endmodule

//--- hdl/lsu.sv
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu
  import cb_pkg::*;
  import lsu_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n_i,
  input  s_lsu_op_t        lsu_i,
  output logic             lsu_bp_o,
  output s_lsu_op_t        wb_lsu_o,
  output logic [`XLEN-1:0] lsu_data_o,
  output logic             done_o,
  output logic             txn_error_o,
  input  logic             wb_busy_i,
  output s_cb_mosi_t       data_cb_mosi_o,
  input  s_cb_miso_t       data_cb_miso_i
);
  s_lsu_op_t lsu_ff;
  s_lsu_op_t next_lsu;
  logic      req_ff;
  logic      next_req;
  logic      wr_resp_ff;
  logic      next_wr_resp;
  logic      rd_txn;
  logic      wr_txn;
  logic      new_txn;
  logic      wr_txn_dp;
  logic      pending;
  logic      bp_addr;
  logic      take;
  logic      wr_data_hs;
  logic      rd_done;
  logic      wr_done;

  function automatic cb_size_t size_txn(lsu_w_t width);
    case (width)
      RV_LSU_B, RV_LSU_BU: return CB_BYTE;
      RV_LSU_H, RV_LSU_HU: return CB_HALF_WORD;
      default:             return CB_WORD;
    endcase
  endfunction

  function automatic cb_strb_t strobe_gen(lsu_w_t width, logic [1:0] offset);
    cb_strb_t mask;
    case (width)
      RV_LSU_B, RV_LSU_BU: mask = cb_strb_t'(4'b0001);
      RV_LSU_H, RV_LSU_HU: mask = cb_strb_t'(4'b0011);
      default:             mask = cb_strb_t'(4'b1111);
    endcase
    return mask << offset;
  endfunction

  // Move store data into the addressed lanes, zero elsewhere
  function automatic cb_data_t lane_data(cb_data_t wdata, cb_strb_t strb, logic [1:0] offset);
    cb_data_t shifted;
    shifted = wdata << {offset, 3'b000};
    for (int i = 0; i < `XLEN/8; i++) begin
      if (!strb[i]) begin
        shifted[i*8 +: 8] = 8'h00;
      end
    end
    return shifted;
  endfunction

  always_comb begin
    rd_txn    = (lsu_i.op_typ == LSU_LOAD);
    wr_txn    = (lsu_i.op_typ == LSU_STORE);
    new_txn   = rd_txn || wr_txn;
    wr_txn_dp = (lsu_ff.op_typ == LSU_STORE);

    // One op on the bus at a time, and none while a response is waiting
    pending  = req_ff || wr_resp_ff || wb_busy_i;
    bp_addr  = new_txn && (rd_txn ? !data_cb_miso_i.rd_addr_ready :
                                    !data_cb_miso_i.wr_addr_ready);
    lsu_bp_o = pending || bp_addr;
    take     = new_txn && !lsu_bp_o;

    data_cb_mosi_o               = '0;
    data_cb_mosi_o.rd_ready      = !wb_busy_i;
    data_cb_mosi_o.wr_resp_ready = !wb_busy_i;

    // Address phase, always word aligned
    if (new_txn && !pending) begin
      if (rd_txn) begin
        data_cb_mosi_o.rd_addr       = {lsu_i.addr[`XLEN-1:2], 2'b00};
        data_cb_mosi_o.rd_size       = size_txn(lsu_i.width);
        data_cb_mosi_o.rd_addr_valid = 1'b1;
      end else begin
        data_cb_mosi_o.wr_addr       = {lsu_i.addr[`XLEN-1:2], 2'b00};
        data_cb_mosi_o.wr_size       = size_txn(lsu_i.width);
        data_cb_mosi_o.wr_addr_valid = 1'b1;
      end
    end

    // Store data phase
    if (req_ff && wr_txn_dp) begin
      data_cb_mosi_o.wr_strobe     = strobe_gen(lsu_ff.width, lsu_ff.addr[1:0]);
      data_cb_mosi_o.wr_data       = lane_data(lsu_ff.wdata, data_cb_mosi_o.wr_strobe,
                                               lsu_ff.addr[1:0]);
      data_cb_mosi_o.wr_data_valid = 1'b1;
    end

    wr_data_hs = req_ff && wr_txn_dp && data_cb_miso_i.wr_data_ready;
    rd_done    = req_ff && !wr_txn_dp && data_cb_miso_i.rd_valid &&
                 data_cb_mosi_o.rd_ready;
    wr_done    = wr_resp_ff && data_cb_miso_i.wr_resp_valid &&
                 data_cb_mosi_o.wr_resp_ready;

    next_req = req_ff;
    if (rd_done || wr_data_hs) begin
      next_req = 1'b0;
    end
    if (take) begin
      next_req = 1'b1;
    end

    // Write response outstanding after the data beat
    next_wr_resp = wr_resp_ff;
    if (wr_done) begin
      next_wr_resp = 1'b0;
    end
    if (wr_data_hs) begin
      next_wr_resp = 1'b1;
    end

    next_lsu = take ? lsu_i : lsu_ff;

    done_o      = rd_done || wr_done;
    txn_error_o = rd_done ? (data_cb_miso_i.rd_resp != CB_OKAY) :
                  wr_done ? (data_cb_miso_i.wr_resp_error != CB_OKAY) : 1'b0;
    wb_lsu_o    = lsu_ff;
    lsu_data_o  = data_cb_miso_i.rd_data;
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      lsu_ff     <= '0;
      req_ff     <= 1'b0;
      wr_resp_ff <= 1'b0;
    end else begin
      lsu_ff     <= next_lsu;
      req_ff     <= next_req;
      wr_resp_ff <= next_wr_resp;
    end
  end

endmodule

//--- hdl/lsu_issue.sv
`timescale 1ns/1ps

module lsu_issue
  import lsu_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n_i,
  input  s_lsu_op_t op_i,
  input  logic      op_req_i,
  output logic      op_ack_o,
  output s_lsu_op_t lsu_op_o,
  input  logic      lsu_bp_i
);
  issue_st_t st_ff;
  issue_st_t next_st;
  s_lsu_op_t op_ff;
  logic      capture;

  always_comb begin
    next_st = st_ff;
    capture = 1'b0;
    case (st_ff)
      IDLE: begin
        if (op_req_i) begin
          capture = 1'b1;
          next_st = HOLD;
        end
      end
      // Op offered to the LSU, taken on the first cycle without stall
      HOLD: begin
        if (!lsu_bp_i) begin
          next_st = WAIT_REQ_LOW;
        end
      end
      WAIT_REQ_LOW: begin
        if (!op_req_i) begin
          next_st = IDLE;
        end
      end
      default: next_st = IDLE;
    endcase

    lsu_op_o = op_ff;
    if (st_ff != HOLD) begin
      lsu_op_o.op_typ = NO_LSU;
    end
    op_ack_o = (st_ff == WAIT_REQ_LOW);
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      st_ff <= IDLE;
    end else begin
      st_ff <= next_st;
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      op_ff <= op_i;
    end
  end

endmodule

//--- hdl/lsu_pkg.sv
`include "lsu_params.svh"

package lsu_pkg;

  typedef enum logic [1:0] {
    NO_LSU    = 2'b00,
    LSU_LOAD  = 2'b01,
    LSU_STORE = 2'b10
  } lsu_op_typ_t;

  // Width codes follow the RV funct3 field of loads and stores
  typedef enum logic [2:0] {
    RV_LSU_B  = 3'b000,
    RV_LSU_H  = 3'b001,
    RV_LSU_W  = 3'b010,
    RV_LSU_BU = 3'b100,
    RV_LSU_HU = 3'b101
  } lsu_w_t;

  typedef struct packed {
    lsu_op_typ_t      op_typ;
    lsu_w_t           width;
    logic [`XLEN-1:0] addr;
    logic [`XLEN-1:0] wdata;
  } s_lsu_op_t;

  // One response per op, rdata is zero for stores
  typedef struct packed {
    lsu_op_typ_t      op_typ;
    logic [`XLEN-1:0] rdata;
    logic             error;
  } s_lsu_rsp_t;

  // Shared by the issue slave and the response master
  typedef enum logic [1:0] {
    IDLE         = 2'b00,
    HOLD         = 2'b01,
    WAIT_REQ_LOW = 2'b10
  } issue_st_t;

endpackage

//--- hdl/cb_pkg.sv
`include "lsu_params.svh"

package cb_pkg;

  typedef logic [`XLEN-1:0]   cb_addr_t;
  typedef logic [`XLEN-1:0]   cb_data_t;
  typedef logic [`XLEN/8-1:0] cb_strb_t;

  typedef enum logic [1:0] {
    CB_BYTE      = 2'b00,
    CB_HALF_WORD = 2'b01,
    CB_WORD      = 2'b10
  } cb_size_t;

  // Only OKAY and SLVERR are produced by the targets here
  typedef enum logic [1:0] {
    CB_OKAY   = 2'b00,
    CB_SLVERR = 2'b10
  } cb_resp_t;

  // Master to slave, read and write channels side by side
  typedef struct packed {
    cb_addr_t rd_addr;
    cb_size_t rd_size;
    logic     rd_addr_valid;
    logic     rd_ready;
    cb_addr_t wr_addr;
    cb_size_t wr_size;
    logic     wr_addr_valid;
    cb_data_t wr_data;
    cb_strb_t wr_strobe;
    logic     wr_data_valid;
    logic     wr_resp_ready;
  } s_cb_mosi_t;

  // Slave to master
  typedef struct packed {
    logic     rd_addr_ready;
    cb_data_t rd_data;
    logic     rd_valid;
    cb_resp_t rd_resp;
    logic     wr_addr_ready;
    logic     wr_data_ready;
    logic     wr_resp_valid;
    cb_resp_t wr_resp_error;
  } s_cb_miso_t;

endpackage

//--- include/lsu_params.svh
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// Data and address width of the core
`define XLEN 32

// Data RAM geometry, in 32-bit words
`define RAM_DEPTH 256
`define RAM_AW 8

// Cycles from read address accepted to rd_valid
`define RAM_RD_LAT 1

`endif
